// File: logic/api_pkg.sv
package api_pkg;

    // Command opcodes
    localparam logic [7:0] OP_REG_WRITE = 8'h01;
    localparam logic [7:0] OP_RAM_WRITE = 8'h02;
    localparam logic [7:0] OP_RAM_READ = 8'h03;
    localparam logic [7:0] OP_STATUS_READ = 8'h04;

    // Response status codes
    localparam logic [7:0] STAT_OK = 8'h5A;
    localparam logic [7:0] STAT_BAD_OP = 8'hE1;

    localparam int IN_CREDITS = 4;   // Input queue depth and host start credits
    localparam int OUT_CREDITS = 4;  // Response credits after reset
    localparam int OUT_CREDIT_BITS = $clog2(OUT_CREDITS + 1);
    localparam int RESULT_DEPTH = 2;

    localparam int RAM_ADDR_BITS = 12;
    localparam int RAM_BYTES = 1 << RAM_ADDR_BITS;
    localparam int REG_ADDR_BITS = 4;

    // Register address rides in the low bits of addr
    typedef struct packed {
        logic [7:0] opcode;
        logic [RAM_ADDR_BITS-1:0] addr;
        logic [31:0] data;
    } api_cmd_t;

    typedef struct packed {
        logic [7:0] status;
        logic [2:0] length;   // Payload byte count of 0, 1 or 4
        logic [31:0] payload; // Sent LSB first
    } api_result_t;

endpackage

// File: logic/credit_queue.sv
`timescale 1ns/1ns

module credit_queue #(
    parameter type payload_t = logic [7:0],
    parameter int DEPTH = 2
) (
    input  logic clk,
    input  logic async_nreset,
    input  logic push,
    input  payload_t data_in,
    input  logic pop,
    output payload_t data_out,
    output logic valid,
    output logic full,
    output logic credit
);
    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];
    logic [PTR_W-1:0] rd_ptr;
    logic [PTR_W-1:0] wr_ptr;
    logic [CNT_W-1:0] count;
    logic do_push;
    logic do_pop;

    function automatic logic [PTR_W-1:0] next_ptr(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(DEPTH - 1)) begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign valid = count != '0;
    assign full = count == CNT_W'(DEPTH);
    assign do_push = push && !full;
    assign do_pop = pop && valid;
    assign credit = do_pop;  // One credit back per item leaving
    assign data_out = mem[rd_ptr];

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            rd_ptr <= '0;
            wr_ptr <= '0;
            count <= '0;
        end else begin
            if (do_push) begin
                wr_ptr <= next_ptr(wr_ptr);
            end
            if (do_pop) begin
                rd_ptr <= next_ptr(rd_ptr);
            end
            if (do_push && !do_pop) begin
                count <= count + 1'b1;
            end else if (do_pop && !do_push) begin
                count <= count - 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (do_push) begin
            mem[wr_ptr] <= data_in;
        end
    end
endmodule

// File: logic/api_decode.sv
`timescale 1ns/1ns

module api_decode (
    input  logic clk,
    input  logic async_nreset,
    input  logic [7:0] byte_data,
    input  logic byte_valid,
    output logic byte_pop,
    output logic cmd_valid,
    output api_pkg::api_cmd_t cmd,
    input  logic cmd_take
);
    import api_pkg::*;

    logic [2:0] cnt;       // Index of the next byte within the command
    logic [7:0] cur_op;
    logic [2:0] last_idx;

    // Index of the final byte for each opcode
    function automatic logic [2:0] last_index(input logic [7:0] op);
        case (op)
            OP_REG_WRITE: return 3'd5;
            OP_RAM_WRITE: return 3'd3;
            OP_RAM_READ: return 3'd2;
            default: return 3'd0;  // STATUS_READ and unknown opcodes
        endcase
    endfunction

    // Opcode byte itself decides the length on the first byte
    assign cur_op = (cnt == 3'd0) ? byte_data : cmd.opcode;
    assign last_idx = last_index(cur_op);

    // Stall while a finished command waits for execute
    assign byte_pop = byte_valid && !cmd_valid;

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            cnt <= '0;
            cmd_valid <= 1'b0;
        end else begin
            if (cmd_take) begin
                cmd_valid <= 1'b0;
            end
            if (byte_pop) begin
                if (cnt == last_idx) begin
                    cnt <= '0;
                    cmd_valid <= 1'b1;
                end else begin
                    cnt <= cnt + 1'b1;
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (byte_pop) begin
            if (cnt == 3'd0) begin
                cmd.opcode <= byte_data;
                cmd.addr <= '0;
                cmd.data <= '0;
            end else if (cmd.opcode == OP_REG_WRITE) begin
                if (cnt == 3'd1) begin
                    cmd.addr <= RAM_ADDR_BITS'(byte_data);  // Register address
                end else begin
                    cmd.data <= {byte_data, cmd.data[31:8]};  // LSB first
                end
            end else begin
                case (cnt)
                    3'd1: cmd.addr <= RAM_ADDR_BITS'(byte_data);
                    3'd2: cmd.addr[RAM_ADDR_BITS-1:8] <= byte_data[RAM_ADDR_BITS-9:0];
                    default: cmd.data <= {24'd0, byte_data};  // RAM_WRITE data
                endcase
            end
        end
    end
endmodule

// File: logic/api_execute.sv
`timescale 1ns/1ns

module api_execute (
    input  logic clk,
    input  logic async_nreset,
    input  logic cmd_valid,
    input  api_pkg::api_cmd_t cmd,
    output logic cmd_take,
    input  logic [31:0] status_word,
    output logic [31:0] wr_reg,
    output logic [api_pkg::REG_ADDR_BITS-1:0] wr_reg_addr,
    output logic wr_reg_changed,
    output logic [api_pkg::RAM_ADDR_BITS-1:0] ram_addr,
    output logic [7:0] ram_wdata,
    output logic ram_we,
    input  logic [7:0] ram_rdata,
    input  logic res_full,
    output logic res_push,
    output api_pkg::api_result_t res_data
);
    import api_pkg::*;

    logic rd_wait;  // Read data present this cycle
    logic go;

    assign go = cmd_valid && !res_full;

    // Memory port follows the held command
    assign ram_addr = cmd.addr;
    assign ram_wdata = cmd.data[7:0];

    always_comb begin
        cmd_take = 1'b0;
        res_push = 1'b0;
        ram_we = 1'b0;
        res_data.status = STAT_OK;
        res_data.length = 3'd0;
        res_data.payload = '0;
        if (go) begin
            case (cmd.opcode)
                OP_REG_WRITE: begin
                    cmd_take = 1'b1;
                    res_push = 1'b1;
                end
                OP_RAM_WRITE: begin
                    cmd_take = 1'b1;
                    res_push = 1'b1;
                    ram_we = 1'b1;
                end
                OP_RAM_READ: begin
                    if (rd_wait) begin
                        cmd_take = 1'b1;
                        res_push = 1'b1;
                        res_data.length = 3'd1;
                        res_data.payload = {24'd0, ram_rdata};
                    end
                end
                OP_STATUS_READ: begin
                    cmd_take = 1'b1;
                    res_push = 1'b1;
                    res_data.length = 3'd4;
                    res_data.payload = status_word;
                end
                default: begin
                    cmd_take = 1'b1;
                    res_push = 1'b1;
                    res_data.status = STAT_BAD_OP;
                end
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            rd_wait <= 1'b0;
            wr_reg <= '0;
            wr_reg_addr <= '0;
            wr_reg_changed <= 1'b0;
        end else begin
            rd_wait <= (go && cmd.opcode == OP_RAM_READ && !rd_wait) || (rd_wait && !cmd_take);
            wr_reg_changed <= 1'b0;
            if (cmd_take && cmd.opcode == OP_REG_WRITE) begin
                wr_reg <= cmd.data;
                wr_reg_addr <= cmd.addr[REG_ADDR_BITS-1:0];
                wr_reg_changed <= 1'b1;  // Single cycle pulse
            end
        end
    end
endmodule

// File: logic/cart_ram.sv
`timescale 1ns/1ns

module cart_ram (
    input  logic clk,
    input  logic async_nreset,
    input  logic [api_pkg::RAM_ADDR_BITS-1:0] addr,
    input  logic [7:0] wdata,
    input  logic we,
    output logic [7:0] rdata,
    output logic busy
);
    import api_pkg::*;

    logic [7:0] mem [RAM_BYTES];
    logic [RAM_ADDR_BITS-1:0] sweep_addr;

    // Zero fill after reset at one byte per cycle
    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            sweep_addr <= '0;
            busy <= 1'b1;
        end else if (busy) begin
            sweep_addr <= sweep_addr + 1'b1;
            if (&sweep_addr) begin
                busy <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (busy) begin
            mem[sweep_addr] <= 8'd0;
        end else if (we) begin
            mem[addr] <= wdata;
        end
        rdata <= mem[addr];  // One cycle read
    end
endmodule

// File: logic/api_result.sv
`timescale 1ns/1ns

module api_result (
    input  logic clk,
    input  logic async_nreset,
    input  logic res_valid,
    input  api_pkg::api_result_t res_data,
    output logic res_pop,
    output logic [7:0] out_data,
    output logic out_valid,
    input  logic out_credit
);
    import api_pkg::*;

    logic [OUT_CREDIT_BITS-1:0] credits;
    logic [2:0] idx;  // 0 is the status byte
    logic [7:0] tx_byte;
    logic send;
    logic last;

    assign send = res_valid && credits != '0;
    assign last = idx == res_data.length;
    assign res_pop = send && last;

    always_comb begin
        case (idx)
            3'd0: tx_byte = res_data.status;
            3'd1: tx_byte = res_data.payload[7:0];
            3'd2: tx_byte = res_data.payload[15:8];
            3'd3: tx_byte = res_data.payload[23:16];
            default: tx_byte = res_data.payload[31:24];
        endcase
    end

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            credits <= OUT_CREDIT_BITS'(OUT_CREDITS);
            idx <= '0;
            out_valid <= 1'b0;
        end else begin
            out_valid <= send;
            if (send) begin
                idx <= last ? 3'd0 : idx + 1'b1;
            end
            case ({send, out_credit})
                2'b10: credits <= credits - 1'b1;
                2'b01: credits <= credits + 1'b1;
                default: credits <= credits;  // None or both
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (send) begin
            out_data <= tx_byte;
        end
    end
endmodule

// File: logic/api_core.sv
`timescale 1ns/1ns

module api_core (
    input  logic clk,
    input  logic async_nreset,
    input  logic [7:0] in_data,
    input  logic in_valid,
    output logic in_credit,
    output logic [7:0] out_data,
    output logic out_valid,
    input  logic out_credit,
    input  logic [31:0] status_word,
    output logic [31:0] wr_reg,
    output logic [api_pkg::REG_ADDR_BITS-1:0] wr_reg_addr,
    output logic wr_reg_changed
);
    import api_pkg::*;

    logic [7:0] byte_data;
    logic byte_valid;
    logic byte_pop;
    logic cmd_valid;
    api_cmd_t cmd;
    logic cmd_take;
    logic [RAM_ADDR_BITS-1:0] ram_addr;
    logic [7:0] ram_wdata;
    logic ram_we;
    logic [7:0] ram_rdata;
    logic ram_busy;
    logic res_push;
    api_result_t res_in;
    api_result_t res_out;
    logic res_valid;
    logic res_pop;
    logic res_q_full;

    credit_queue #(.payload_t(logic [7:0]), .DEPTH(IN_CREDITS)) in_q (
        .clk(clk),
        .async_nreset(async_nreset),
        .push(in_valid),
        .data_in(in_data),
        .pop(byte_pop),
        .data_out(byte_data),
        .valid(byte_valid),
        .full(),
        .credit(in_credit)  // Straight back to the host
    );

    api_decode decode (
        .clk(clk),
        .async_nreset(async_nreset),
        .byte_data(byte_data),
        .byte_valid(byte_valid),
        .byte_pop(byte_pop),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .cmd_take(cmd_take)
    );

    // Execute stalls while memory is still being cleared
    api_execute execute (
        .clk(clk),
        .async_nreset(async_nreset),
        .cmd_valid(cmd_valid),
        .cmd(cmd),
        .cmd_take(cmd_take),
        .status_word(status_word),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed),
        .ram_addr(ram_addr),
        .ram_wdata(ram_wdata),
        .ram_we(ram_we),
        .ram_rdata(ram_rdata),
        .res_full(res_q_full || ram_busy),
        .res_push(res_push),
        .res_data(res_in)
    );

    cart_ram ram (
        .clk(clk),
        .async_nreset(async_nreset),
        .addr(ram_addr),
        .wdata(ram_wdata),
        .we(ram_we),
        .rdata(ram_rdata),
        .busy(ram_busy)
    );

    credit_queue #(.payload_t(api_result_t), .DEPTH(RESULT_DEPTH)) res_q (
        .clk(clk),
        .async_nreset(async_nreset),
        .push(res_push),
        .data_in(res_in),
        .pop(res_pop),
        .data_out(res_out),
        .valid(res_valid),
        .full(res_q_full),
        .credit()
    );

    api_result result (
        .clk(clk),
        .async_nreset(async_nreset),
        .res_valid(res_valid),
        .res_data(res_out),
        .res_pop(res_pop),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_credit(out_credit)
    );
endmodule

// File: verification/api_core_checker.sv
`timescale 1ns/1ns

module api_core_checker (
    input logic clk,
    input logic async_nreset,
    input logic in_valid,
    input logic in_credit,
    input logic out_valid,
    input logic out_credit,
    input logic wr_reg_changed
);
    import api_pkg::*;

    logic [3:0] in_held;   // Input bytes sent and not yet credited
    logic [3:0] out_used;  // Response bytes not yet credited back
    logic pulse_d;
    logic in_over;
    logic out_over;
    logic pulse_long;
    logic fault;           // Sticky failure flag

    assign in_over = in_credit && in_held == '0;
    assign out_over = out_valid && out_used >= 4'(OUT_CREDITS);
    assign pulse_long = wr_reg_changed && pulse_d;

    always_ff @(posedge clk) begin
        if (!async_nreset) begin
            in_held <= '0;
            out_used <= '0;
            pulse_d <= 1'b0;
            fault <= 1'b0;
        end else begin
            in_held <= in_held + 4'(in_valid) - 4'(in_credit);
            out_used <= out_used + 4'(out_valid) - 4'(out_credit);
            pulse_d <= wr_reg_changed;
            if (in_over || out_over || pulse_long) begin
                fault <= 1'b1;
            end
        end
    end

    assert property (@(posedge clk) disable iff (!async_nreset) !in_over)
        else $error("in_credit returned with no input byte outstanding");
    assert property (@(posedge clk) disable iff (!async_nreset) !out_over)
        else $error("Response byte sent beyond the granted credits");
    assert property (@(posedge clk) disable iff (!async_nreset) !pulse_long)
        else $error("wr_reg_changed held for more than one cycle");
endmodule

// File: verification/api_core_tb.sv
`timescale 1ns/1ns

module api_core_tb;
    import api_pkg::*;

    localparam int N_CMDS = 80;
    // RAM clear sweep plus a budget per command
    localparam int TIMEOUT = RAM_BYTES + N_CMDS * 40;

    logic clk;
    logic async_nreset;
    logic [7:0] in_data;
    logic in_valid;
    logic in_credit;
    logic [7:0] out_data;
    logic out_valid;
    logic out_credit;
    logic [31:0] status_word;
    logic [31:0] wr_reg;
    logic [REG_ADDR_BITS-1:0] wr_reg_addr;
    logic wr_reg_changed;

    logic [7:0] send_q[$];  // Host byte stream
    logic [7:0] exp_bytes[$];
    int exp_lens[$];        // Bytes per response with status
    logic [REG_ADDR_BITS-1:0] exp_reg_addr[$];
    logic [31:0] exp_reg_data[$];
    logic [7:0] ram_model [int];
    logic [RAM_ADDR_BITS-1:0] addr_pool [8];
    int host_credits;
    int owed;
    int stall;
    int remaining;
    int resp_count;
    int cycles;

    api_core DUT (
        .clk(clk),
        .async_nreset(async_nreset),
        .in_data(in_data),
        .in_valid(in_valid),
        .in_credit(in_credit),
        .out_data(out_data),
        .out_valid(out_valid),
        .out_credit(out_credit),
        .status_word(status_word),
        .wr_reg(wr_reg),
        .wr_reg_addr(wr_reg_addr),
        .wr_reg_changed(wr_reg_changed)
    );

    bind api_core api_core_checker credit_check (
        .clk(clk),
        .async_nreset(async_nreset),
        .in_valid(in_valid),
        .in_credit(in_credit),
        .out_valid(out_valid),
        .out_credit(out_credit),
        .wr_reg_changed(wr_reg_changed)
    );

    task automatic stop_with_failure(input string line);
        $display("%s", line);
        $display("Testbench failed");
        $fatal(1);
    endtask

    function automatic logic [RAM_ADDR_BITS-1:0] pick_addr();
        if ($urandom % 4 == 0) begin
            return RAM_ADDR_BITS'($urandom);  // Most likely never written
        end
        return addr_pool[3'($urandom)];
    endfunction

    task automatic expect_response(input logic [7:0] status, input int len,
                                   input logic [31:0] payload);
        exp_bytes.push_back(status);
        for (int i = 0; i < len; i++) begin
            exp_bytes.push_back(payload[8*i +: 8]);
        end
        exp_lens.push_back(len + 1);
    endtask

    task automatic build_commands();
        int kind;
        logic [7:0] op;
        logic [7:0] reg_addr;
        logic [7:0] wbyte;
        logic [31:0] data;
        logic [RAM_ADDR_BITS-1:0] a;
        for (int n = 0; n < N_CMDS; n++) begin
            kind = (n < 5) ? n : int'($urandom % 5);  // Every kind once up front
            a = pick_addr();
            case (kind)
                0: begin
                    reg_addr = 8'($urandom);
                    data = $urandom;
                    send_q.push_back(OP_REG_WRITE);
                    send_q.push_back(reg_addr);
                    for (int i = 0; i < 4; i++) begin
                        send_q.push_back(data[8*i +: 8]);
                    end
                    exp_reg_addr.push_back(reg_addr[REG_ADDR_BITS-1:0]);
                    exp_reg_data.push_back(data);
                    expect_response(STAT_OK, 0, '0);
                end
                1: begin
                    wbyte = 8'($urandom);
                    send_q.push_back(OP_RAM_WRITE);
                    send_q.push_back(a[7:0]);
                    send_q.push_back(8'(a[RAM_ADDR_BITS-1:8]));
                    send_q.push_back(wbyte);
                    ram_model[int'(a)] = wbyte;
                    expect_response(STAT_OK, 0, '0);
                end
                2: begin
                    wbyte = ram_model.exists(int'(a)) ? ram_model[int'(a)] : 8'd0;
                    send_q.push_back(OP_RAM_READ);
                    send_q.push_back(a[7:0]);
                    send_q.push_back(8'(a[RAM_ADDR_BITS-1:8]));
                    expect_response(STAT_OK, 1, {24'd0, wbyte});
                end
                3: begin
                    send_q.push_back(OP_STATUS_READ);
                    expect_response(STAT_OK, 4, status_word);
                end
                default: begin
                    op = ($urandom % 4 == 0) ? 8'h00 : 8'($urandom_range(255, 5));
                    send_q.push_back(op);
                    expect_response(STAT_BAD_OP, 0, '0);
                end
            endcase
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

    initial begin
        async_nreset = 1'b0;
        in_data = '0;
        in_valid = 1'b0;
        out_credit = 1'b0;
        void'($urandom(32'ha5ef));
        status_word = $urandom;
        for (int i = 0; i < 8; i++) begin
            addr_pool[i] = RAM_ADDR_BITS'($urandom);
        end
        build_commands();
        repeat (5) @(posedge clk);
        async_nreset <= 1'b1;
        wait (resp_count == N_CMDS);
        repeat (10) @(posedge clk);  // Room for stray bytes
        if (exp_reg_data.size() != 0) begin
            stop_with_failure("Expected register writes never arrived");
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

    // Host side of the input link
    always @(posedge clk) begin
        if (!async_nreset) begin
            in_valid <= 1'b0;
            host_credits = IN_CREDITS;
        end else begin
            if (in_credit) begin
                host_credits++;
            end
            if (host_credits > 0 && send_q.size() > 0) begin
                in_data <= send_q.pop_front();
                in_valid <= 1'b1;
                host_credits--;
            end else begin
                in_valid <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        logic [7:0] expected;
        if (!async_nreset) begin
            out_credit <= 1'b0;
            owed = 0;
            stall = 0;
            remaining = 0;
        end else begin
            if (out_valid) begin
                if (exp_bytes.size() == 0) begin
                    stop_with_failure($sformatf("ERROR at %0t ns: unexpected byte %02h",
                                                $time, out_data));
                end else begin
                    expected = exp_bytes.pop_front();
                    assert (out_data == expected)
                        else stop_with_failure($sformatf(
                            "ERROR at %0t ns: out_data %02h, expected %02h",
                            $time, out_data, expected));
                    if (remaining == 0) begin
                        remaining = exp_lens.pop_front();
                    end
                    remaining--;
                    if (remaining == 0) begin
                        resp_count++;
                    end
                    owed++;
                end
            end
            if (stall > 0) begin
                stall--;
            end else if ($urandom % 10 == 0) begin
                stall = int'($urandom % 24);  // Withhold credits for a while
            end
            if (owed > 0 && stall == 0) begin
                out_credit <= 1'b1;
                owed--;
            end else begin
                out_credit <= 1'b0;
            end
        end
    end

    always @(posedge clk) begin
        logic [31:0] exp_data;
        logic [REG_ADDR_BITS-1:0] exp_addr;
        if (async_nreset && wr_reg_changed) begin
            if (exp_reg_data.size() == 0) begin
                stop_with_failure($sformatf("ERROR at %0t ns: unexpected register write",
                                            $time));
            end else begin
                exp_data = exp_reg_data.pop_front();
                exp_addr = exp_reg_addr.pop_front();
                assert (wr_reg == exp_data && wr_reg_addr == exp_addr)
                    else stop_with_failure($sformatf(
                        "ERROR at %0t ns: wr_reg %h at %h, expected %h at %h",
                        $time, wr_reg, wr_reg_addr, exp_data, exp_addr));
            end
        end
    end

    always @(posedge clk) begin
        cycles++;
        if (DUT.credit_check.fault) begin
            stop_with_failure("A bound credit or register pulse assertion failed");
        end else if (cycles > TIMEOUT) begin
            stop_with_failure($sformatf("Timeout after %0d cycles with %0d of %0d responses",
                                        cycles, resp_count, N_CMDS));
        end
    end
endmodule

// File: files.f
logic/api_pkg.sv
logic/credit_queue.sv
logic/api_decode.sv
logic/api_execute.sv
logic/cart_ram.sv
logic/api_result.sv
logic/api_core.sv
verification/api_core_checker.sv
verification/api_core_tb.sv

// File: Makefile
.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove build output and the log"

test:
	verilator --binary --timing --assert -f files.f --top-module api_core_tb -Mdir obj_dir -o sim
	./obj_dir/sim +verilator+error+limit+10 > sim.log 2>&1 || true
	@cat sim.log
	@if grep -q "Testbench failed" sim.log; then exit 1; fi
	@grep -q "Testbench passed" sim.log

clean:
	rm -rf obj_dir sim.log
